// File: hw/nabp_geometry_pkg.sv
package nabp_geometry_pkg;

    // image geometry
    localparam int IMAGE_SIZE = 8;
    localparam int PARTITION_SIZE = 2;
    localparam int NO_OF_PARTITIONS = 4;
    localparam int IMAGE_PIXELS = IMAGE_SIZE * IMAGE_SIZE;

    // data widths, a pixel holds the sum of two values
    localparam int VALUE_WIDTH = 12;
    localparam int PIXEL_WIDTH = 16;

    // credits granted after reset match the fifo slots
    localparam int BUFFER_DEPTH = 4;

    localparam int ADDR_WIDTH = $clog2(IMAGE_PIXELS);
    localparam int POS_WIDTH = $clog2(IMAGE_SIZE);
    localparam int PARTITION_WIDTH = $clog2(NO_OF_PARTITIONS);
    localparam int LINE_WIDTH = $clog2(PARTITION_SIZE);
    localparam int PTR_WIDTH = $clog2(BUFFER_DEPTH);
    localparam int COUNT_WIDTH = $clog2(BUFFER_DEPTH + 1);

    typedef logic [ADDR_WIDTH-1:0] image_addr_t;
    typedef logic [POS_WIDTH-1:0] pixel_pos_t;
    typedef logic [PARTITION_WIDTH-1:0] partition_t;
    typedef logic [LINE_WIDTH-1:0] line_t;
    typedef logic [VALUE_WIDTH-1:0] sample_value_t;
    typedef logic [PIXEL_WIDTH-1:0] pixel_t;

endpackage

// File: hw/nabp_control_pkg.sv
package nabp_control_pkg;

    // addresser fsm
    typedef enum logic [1:0] {
        ready_s,
        delay_s,
        addressing_x_s,
        addressing_y_s
    } addresser_state_t;

    // x scan stores, y scan accumulates
    typedef enum logic {
        scan_x,
        scan_y
    } scan_mode_t;

endpackage

// File: hw/ir_stream_if.sv
`timescale 1ns/100ps

interface ir_stream_if
    import nabp_geometry_pkg::*, nabp_control_pkg::*;
();

    // head of the sample fifo
    logic value_valid;
    sample_value_t value;

    // pop strobe plus where and how to apply the value
    logic consume;
    image_addr_t addr;
    scan_mode_t mode;

    modport buffer (
        output value_valid,
        output value,
        input  consume
    );

    modport addresser (
        input  value_valid,
        output consume,
        output addr,
        output mode
    );

    modport memory (
        input consume,
        input value,
        input addr,
        input mode
    );

endinterface

// File: hw/sample_credit_buffer.sv
`timescale 1ns/100ps

module sample_credit_buffer
    import nabp_geometry_pkg::*;
(
    input  logic          clk,
    input  logic          reset_n,
    input  logic          sample_valid,
    input  sample_value_t sample_value,
    output logic          sample_credit,
    ir_stream_if.buffer   ir
);

    sample_value_t slots [BUFFER_DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic [COUNT_WIDTH-1:0] credit_pending;

    logic push;
    logic pop;
    logic credit_issue;

    // circular pointer advance
    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(BUFFER_DEPTH - 1))
            return '0;
        else
            return ptr + 1'b1;
    endfunction

    // sender only sends while holding a credit, so a push always has room
    assign push = sample_valid;
    assign pop = ir.consume;

    assign ir.value_valid = (count != '0);
    assign ir.value = slots[rd_ptr];

    // slot storage
    always_ff @(posedge clk)
    begin
        if (push)
            slots[wr_ptr] <= sample_value;
    end

    // pointers and fill level
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:
                    count <= count + 1'b1;
                2'b01:
                    count <= count - 1'b1;
                default:
                    count <= count;
            endcase
        end
    end

    // one pulse per cycle, initial grant first, then one per freed slot
    assign credit_issue = (credit_pending != '0) || pop;

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            credit_pending <= COUNT_WIDTH'(BUFFER_DEPTH);
            sample_credit <= 1'b0;
        end
        else
        begin
            sample_credit <= credit_issue;
            // a pop during the grant burst is queued behind it
            credit_pending <= credit_pending + COUNT_WIDTH'(pop)
                              - COUNT_WIDTH'(credit_issue);
        end
    end

endmodule

// File: hw/image_addresser.sv
`timescale 1ns/100ps

module image_addresser
    import nabp_geometry_pkg::*, nabp_control_pkg::*;
(
    input  logic           clk,
    input  logic           reset_n,
    input  logic           kick,
    output logic           kick_ack,
    output logic           busy,
    ir_stream_if.addresser ir
);

    addresser_state_t state;
    addresser_state_t next_state;

    // delay count, later the current partition
    partition_t pe_pos;
    // pixel within the current row or column
    pixel_pos_t scan_pos;
    // row or column within the band
    line_t line_pos;

    image_addr_t base_addr;
    image_addr_t off_x;
    image_addr_t off_y;

    logic addressing;
    logic pe_done;
    logic scan_done;
    logic line_done;
    logic band_done;
    logic delay_done;

    assign addressing = (state == addressing_x_s) || (state == addressing_y_s);
    assign pe_done = (pe_pos == partition_t'(NO_OF_PARTITIONS - 1));
    assign scan_done = (scan_pos == pixel_pos_t'(IMAGE_SIZE - 1));
    assign line_done = (line_pos == line_t'(PARTITION_SIZE - 1));
    assign band_done = scan_done && line_done;
    assign delay_done = (state == delay_s) && pe_done;

    // mealy outputs
    assign kick_ack = delay_done;
    assign busy = (state != ready_s);

    assign ir.consume = ir.value_valid && addressing;
    assign ir.mode = (state == addressing_y_s) ? scan_y : scan_x;
    assign ir.addr = base_addr + ((ir.mode == scan_x) ? off_x : off_y);

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (kick)
                    next_state = delay_s;
            delay_s:
                if (delay_done)
                    next_state = addressing_x_s;
            addressing_x_s:
                if (ir.consume && band_done)
                    next_state = addressing_y_s;
            addressing_y_s:
                if (ir.consume && band_done)
                    next_state = pe_done ? ready_s : addressing_x_s;
            default:
                next_state = ready_s;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
            state <= ready_s;
        else
            state <= next_state;
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            pe_pos <= '0;
            scan_pos <= '0;
            line_pos <= '0;
            base_addr <= '0;
            off_x <= '0;
            off_y <= '0;
        end
        else
        begin
            case (state)
                ready_s:
                begin
                    pe_pos <= '0;
                    scan_pos <= '0;
                    line_pos <= '0;
                    base_addr <= '0;
                    off_x <= '0;
                    off_y <= '0;
                end
                delay_s:
                begin
                    // models the fill time of the pe chain
                    if (delay_done)
                        pe_pos <= '0;
                    else
                        pe_pos <= pe_pos + 1'b1;
                end
                addressing_x_s, addressing_y_s:
                begin
                    if (ir.consume)
                    begin
                        scan_pos <= scan_done ? '0 : scan_pos + 1'b1;
                        if (scan_done)
                            line_pos <= line_done ? '0 : line_pos + 1'b1;

                        // x walks rows by one, y walks columns by a row stride
                        if (band_done)
                            base_addr <= '0;
                        else if (state == addressing_y_s && scan_done)
                            base_addr <= image_addr_t'(line_pos) + image_addr_t'(1);
                        else if (state == addressing_y_s)
                            base_addr <= base_addr + image_addr_t'(IMAGE_SIZE);
                        else
                            base_addr <= base_addr + image_addr_t'(1);

                        // next band once its y scan is complete
                        if (band_done && state == addressing_y_s)
                        begin
                            pe_pos <= pe_pos + 1'b1;
                            off_x <= off_x + image_addr_t'(PARTITION_SIZE * IMAGE_SIZE);
                            off_y <= off_y + image_addr_t'(PARTITION_SIZE);
                        end
                    end
                end
            endcase
        end
    end

endmodule

// File: hw/image_accumulator.sv
`timescale 1ns/100ps

module image_accumulator
    import nabp_geometry_pkg::*, nabp_control_pkg::*;
(
    input  logic        clk,
    input  image_addr_t rd_addr,
    output pixel_t      rd_data,
    ir_stream_if.memory ir
);

    pixel_t image [IMAGE_PIXELS];

    pixel_t value_ext;
    pixel_t stored_word;
    pixel_t sum_word;

    // values are unsigned
    assign value_ext = pixel_t'(ir.value);
    assign stored_word = image[ir.addr];
    assign sum_word = stored_word + value_ext;

    // x scan overwrites, so a new frame fully replaces the old image
    always_ff @(posedge clk)
    begin
        if (ir.consume)
        begin
            if (ir.mode == scan_y)
                image[ir.addr] <= sum_word;
            else
                image[ir.addr] <= value_ext;
        end
    end

    // host read port, one cycle latency
    always_ff @(posedge clk)
    begin
        rd_data <= image[rd_addr];
    end

endmodule

// File: hw/nabp_image_unit.sv
`timescale 1ns/100ps

module nabp_image_unit
    import nabp_geometry_pkg::*;
(
    input  logic          clk,
    input  logic          reset_n,

    // frame control
    input  logic          kick,
    output logic          kick_ack,
    output logic          busy,

    // sample stream from the pe chain
    input  logic          sample_valid,
    input  sample_value_t sample_value,
    output logic          sample_credit,

    // host read port
    input  image_addr_t   rd_addr,
    output pixel_t        rd_data
);

    ir_stream_if ir ();

    // credit managed fifo in front of the image ram
    sample_credit_buffer u_buffer (
        .clk           (clk),
        .reset_n       (reset_n),
        .sample_valid  (sample_valid),
        .sample_value  (sample_value),
        .sample_credit (sample_credit),
        .ir            (ir.buffer)
    );

    // scan order and address per consumed value
    image_addresser u_addresser (
        .clk      (clk),
        .reset_n  (reset_n),
        .kick     (kick),
        .kick_ack (kick_ack),
        .busy     (busy),
        .ir       (ir.addresser)
    );

    // write or add image ram
    image_accumulator u_memory (
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .ir      (ir.memory)
    );

endmodule

// File: verification/nabp_image_unit_asserts.sv
`timescale 1ns/100ps

module nabp_image_unit_asserts
    import nabp_geometry_pkg::*, nabp_control_pkg::*;
(
    input logic                   clk,
    input logic                   reset_n,
    input logic [COUNT_WIDTH-1:0] fill_count,
    input logic                   value_valid,
    input sample_value_t          head_value,
    input logic                   consume,
    input logic                   kick_ack,
    input addresser_state_t       state
);

    // count of failed assertions
    int failure_count = 0;

    // credits keep the fifo from overfilling
    fill_limit: assert property (
        @(posedge clk) disable iff (reset_n)
        fill_count <= COUNT_WIDTH'(BUFFER_DEPTH))
    else
    begin
        failure_count++;
        $error("buffer fill level %0d above depth", fill_count);
    end

    // only a valid, written head may be popped
    consume_needs_valid: assert property (
        @(posedge clk) disable iff (reset_n)
        consume |-> value_valid && !$isunknown(head_value))
    else
    begin
        failure_count++;
        $error("consume without a valid head value");
    end

    kick_ack_single: assert property (
        @(posedge clk) disable iff (reset_n)
        kick_ack |=> !kick_ack)
    else
    begin
        failure_count++;
        $error("kick_ack longer than one cycle");
    end

    // pe chain fill delay
    delay_length: assert property (
        @(posedge clk) disable iff (reset_n)
        (state != delay_s) ##1 (state == delay_s)
            |-> (state == delay_s) [*NO_OF_PARTITIONS] ##1 (state == addressing_x_s))
    else
    begin
        failure_count++;
        $error("delay state did not last the partition count");
    end

endmodule

// File: verification/nabp_image_unit_tb.sv
`timescale 1ns/100ps

module nabp_image_unit_tb
    import nabp_geometry_pkg::*;
();

    localparam int FRAME_VALUES = 2 * IMAGE_PIXELS;
    // two frames of 128 values at up to four cycles each, readback and margin
    localparam int TIMEOUT_CYCLES = 2500;
    localparam int SEED = 85087;
    localparam int STALL_PERCENT = 40;

    typedef sample_value_t frame_t [FRAME_VALUES];
    typedef pixel_t image_t [IMAGE_PIXELS];

    logic clk;
    logic reset_n;
    logic kick;
    logic kick_ack;
    logic busy;
    logic sample_valid;
    sample_value_t sample_value;
    logic sample_credit;
    image_addr_t rd_addr;
    pixel_t rd_data;

    frame_t frame_values;
    image_t expected;
    int credits_received;
    int sent_total;
    int cycle_count;
    int check_count;
    int error_count;

    nabp_image_unit UUT (
        .clk           (clk),
        .reset_n       (reset_n),
        .kick          (kick),
        .kick_ack      (kick_ack),
        .busy          (busy),
        .sample_valid  (sample_valid),
        .sample_value  (sample_value),
        .sample_credit (sample_credit),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    bind nabp_image_unit nabp_image_unit_asserts u_asserts (
        .clk         (clk),
        .reset_n     (reset_n),
        .fill_count  (u_buffer.count),
        .value_valid (ir.value_valid),
        .head_value  (ir.value),
        .consume     (ir.consume),
        .kick_ack    (kick_ack),
        .state       (u_addresser.state)
    );

    always #5 clk = ~clk;

    // credits granted to the sender so far
    always @(posedge clk)
    begin
        if (sample_credit === 1'b1)
            credits_received++;
    end

    // expected image, replaying x stores and y adds band by band
    function automatic image_t reference_image(input frame_t vals);
        image_t model;
        int k;
        int p;
        int line;
        int pos;
        int pixel;
        k = 0;
        foreach (model[i])
            model[i] = '0;
        for (p = 0; p < NO_OF_PARTITIONS; p++)
        begin
            for (line = 0; line < PARTITION_SIZE; line++)
            begin
                for (pos = 0; pos < IMAGE_SIZE; pos++)
                begin
                    pixel = (p * PARTITION_SIZE + line) * IMAGE_SIZE + pos;
                    model[pixel] = pixel_t'(vals[k]);
                    k++;
                end
            end
            // a y add into a lower band is overwritten by that band's x scan
            for (line = 0; line < PARTITION_SIZE; line++)
            begin
                for (pos = 0; pos < IMAGE_SIZE; pos++)
                begin
                    pixel = pos * IMAGE_SIZE + p * PARTITION_SIZE + line;
                    model[pixel] = model[pixel] + pixel_t'(vals[k]);
                    k++;
                end
            end
        end
        return model;
    endfunction

    function automatic int total_errors();
        return error_count + UUT.u_asserts.failure_count;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] want,
                                   input logic [31:0] got);
        error_count++;
        $display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, want, got);
    endtask

    task automatic report_error(input string text);
        error_count++;
        $display("error at %0t ns: %s", $time, text);
    endtask

    task automatic print_summary();
        $display("summary: %0d checks, %0d testbench errors, %0d assertion failures",
                 check_count, error_count, UUT.u_asserts.failure_count);
    endtask

    task automatic fill_frame();
        foreach (frame_values[i])
            frame_values[i] = sample_value_t'($urandom);
    endtask

    // sends values first to last-1, one per held credit
    task automatic send_values(input int first, input int last, input int stall_pct);
        int idx;
        idx = first;
        while (idx < last)
        begin
            @(posedge clk);
            #1;
            sample_valid = 1'b0;
            if ((credits_received - sent_total) > 0 && ($urandom % 100) >= stall_pct)
            begin
                sample_valid = 1'b1;
                sample_value = frame_values[idx];
                idx++;
                sent_total++;
            end
        end
        @(posedge clk);
        #1;
        sample_valid = 1'b0;
    endtask

    task automatic start_frame();
        int cycles;
        @(posedge clk);
        #1;
        kick = 1'b1;
        @(posedge clk);
        #1;
        kick = 1'b0;
        // count delay cycles from the one after the kick edge
        cycles = 1;
        while (kick_ack !== 1'b1 && cycles <= 2 * NO_OF_PARTITIONS)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        check_count++;
        if (kick_ack !== 1'b1)
            report_error("kick_ack never pulsed after kick");
        else if (cycles != NO_OF_PARTITIONS)
            report_mismatch("kick_ack delay", NO_OF_PARTITIONS, cycles);
        check_count++;
        if (busy !== 1'b1)
            report_mismatch("busy", 1, busy);
        @(posedge clk);
        #1;
        check_count++;
        if (kick_ack !== 1'b0)
            report_mismatch("kick_ack", 0, kick_ack);
    endtask

    task automatic compare_image();
        int addr;
        for (addr = 0; addr < IMAGE_PIXELS; addr++)
        begin
            rd_addr = image_addr_t'(addr);
            @(posedge clk);
            #1;
            check_count++;
            if (rd_data !== expected[addr])
                report_mismatch($sformatf("rd_data[%0d]", addr), expected[addr], rd_data);
        end
    endtask

    task automatic finish_frame();
        while (busy !== 1'b0)
        begin
            @(posedge clk);
            #1;
        end
        // last credit shows up a cycle after the final consume
        repeat (3) @(posedge clk);
        #1;
        check_count++;
        if (credits_received != sent_total + BUFFER_DEPTH)
            report_mismatch("sample_credit total", sent_total + BUFFER_DEPTH, credits_received);
        expected = reference_image(frame_values);
        compare_image();
    endtask

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the frames did not finish", cycle_count);
        print_summary();
        $display("Test failed");
        $finish;
    end

    initial
    begin
        clk = 1'b0;
        reset_n = 1'b1;
        kick = 1'b0;
        sample_valid = 1'b0;
        sample_value = '0;
        rd_addr = '0;
        credits_received = 0;
        sent_total = 0;
        check_count = 0;
        error_count = 0;
        void'($urandom(SEED));
        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b0;

        // initial credit burst with nothing sent
        repeat (10) @(posedge clk);
        #1;
        check_count += 3;
        if (credits_received != BUFFER_DEPTH)
            report_mismatch("sample_credit count", BUFFER_DEPTH, credits_received);
        if (busy !== 1'b0)
            report_mismatch("busy", 0, busy);
        if (kick_ack !== 1'b0)
            report_mismatch("kick_ack", 0, kick_ack);

        // first frame, head of the frame queued before kick, then full rate
        fill_frame();
        send_values(0, BUFFER_DEPTH, 0);
        repeat (4) @(posedge clk);
        #1;
        check_count++;
        if (credits_received != BUFFER_DEPTH)
            report_error("values were consumed before kick");
        start_frame();
        send_values(BUFFER_DEPTH, FRAME_VALUES, 0);
        finish_frame();

        // second frame with new values and random stalls
        fill_frame();
        start_frame();
        send_values(0, FRAME_VALUES, STALL_PERCENT);
        finish_frame();

        print_summary();
        if (total_errors() == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: vlog.f
hw/nabp_geometry_pkg.sv
hw/nabp_control_pkg.sv
hw/ir_stream_if.sv
hw/sample_credit_buffer.sv
hw/image_addresser.sv
hw/image_accumulator.sv
hw/nabp_image_unit.sv
verification/nabp_image_unit_asserts.sv
verification/nabp_image_unit_tb.sv
